/* verilog/hififo_pkg.sv */
// shared TLP opcodes, register indices and sizing constants for the bridge

package hififo_pkg;

   // stream beat width
   localparam int DATA_W = 64;

   // user FIFO sizing, in 32-bit words
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_AW = 4;

   // returned by a read of REG_ID
   localparam logic [31:0] BRIDGE_ID = 32'h4846_0001;

   // bit 0 FIFO became non-empty, bit 1 write lost to overflow
   localparam int NUM_INT = 2;

   // fmt/type byte of header DW0
   typedef enum logic [7:0]
   {
      MRD32 = 8'h00,
      MWR32 = 8'h40,
      CPLD  = 8'h4A
   } tlp_kind_e;

   // register index, address bits 6:3
   typedef enum logic [3:0]
   {
      REG_INT_STATUS  = 4'd0,
      REG_ID          = 4'd1,
      REG_RESET_SET   = 4'd3,
      REG_RESET_CLEAR = 4'd4,
      REG_FIFO_DATA   = 4'd8,
      REG_FIFO_STATUS = 4'd9
   } reg_addr_e;

endpackage

/* verilog/pcie_rx.sv */
// receive decoder for 3-DW memory write and memory read request TLPs

`timescale 1ns/1ps

module pcie_rx
  (
   input                               clock,
   input                               pci_reset,
   input                               tvalid,
   input                               tlast,
   input        [hififo_pkg::DATA_W-1:0] tdata,
   input                               rr_ready,
   output logic                        wr_strobe,
   output hififo_pkg::reg_addr_e       wr_index,
   output logic [31:0]                 wr_data,
   output logic                        rr_valid,
   output hififo_pkg::reg_addr_e       rr_index,
   output logic [23:0]                 rr_rid_tag,
   output logic [6:0]                  rr_lower_addr
   );

   typedef enum logic
   {
      HEADER,
      ADDRESS
   } rx_state_e;

   rx_state_e             state;
   hififo_pkg::tlp_kind_e kind;
   logic [23:0]           hdr_rid_tag;

   // header fields, captured on beat 0
   always_ff @(posedge clock)
   begin
      if (tvalid && (state == HEADER))
      begin
         kind <= hififo_pkg::tlp_kind_e'(tdata[31:24]);
         // requester ID and tag from DW1
         hdr_rid_tag <= tdata[63:40];
      end
   end

   always_ff @(posedge clock)
   begin
      if (pci_reset)
         state <= HEADER;
      else if (tvalid)
      begin
         case (state)
            HEADER:
            begin
               if (!tlast)
                  state <= ADDRESS;
            end
            ADDRESS:
            begin
               // anything longer is skipped here until tlast
               if (tlast)
                  state <= HEADER;
            end
            default:
               state <= HEADER;
         endcase
      end
   end

   // one strobe per memory write
   always_ff @(posedge clock)
   begin
      if (pci_reset)
         wr_strobe <= 1'b0;
      else
         wr_strobe <= tvalid && (state == ADDRESS) && (kind == hififo_pkg::MWR32);
   end

   always_ff @(posedge clock)
   begin
      if (tvalid && (state == ADDRESS))
      begin
         wr_index <= hififo_pkg::reg_addr_e'(tdata[6:3]);
         wr_data <= tdata[63:32];
      end
   end

   // single request slot, a read arriving while it is full is dropped
   always_ff @(posedge clock)
   begin
      if (pci_reset)
         rr_valid <= 1'b0;
      else if (rr_valid)
      begin
         if (rr_ready)
            rr_valid <= 1'b0;
      end
      else if (tvalid && (state == ADDRESS) && (kind == hififo_pkg::MRD32))
         rr_valid <= 1'b1;
   end

   always_ff @(posedge clock)
   begin
      if (!rr_valid && tvalid && (state == ADDRESS) && (kind == hififo_pkg::MRD32))
      begin
         rr_index <= hififo_pkg::reg_addr_e'(tdata[6:3]);
         rr_rid_tag <= hdr_rid_tag;
         // DW aligned, byte enables are always 4'hF
         rr_lower_addr <= {tdata[6:2], 2'b00};
      end
   end

endmodule

/* verilog/hififo_regs.sv */
// control registers, interrupt status and request, read completion data mux

`timescale 1ns/1ps

module hififo_regs
  (
   input                                clock,
   input                                pci_reset,
   input                                wr_strobe,
   input  hififo_pkg::reg_addr_e        wr_index,
   input        [31:0]                  wr_data,
   input                                rr_valid,
   input  hififo_pkg::reg_addr_e        rr_index,
   input        [23:0]                  rr_rid_tag,
   input        [6:0]                   rr_lower_addr,
   output logic                         rr_ready,
   input        [hififo_pkg::NUM_INT-1:0] int_events,
   input        [31:0]                  fifo_status,
   output logic                         fifo_reset,
   output logic                         interrupt,
   input                                interrupt_rdy,
   output logic                         rc_valid,
   output logic [31:0]                  rc_data,
   output logic [23:0]                  rc_rid_tag,
   output logic [6:0]                   rc_lower_addr,
   input                                rc_ready
   );

   logic                          busy;
   logic                          read_0;
   logic                          status_read;
   logic [hififo_pkg::NUM_INT-1:0] int_status;
   hififo_pkg::reg_addr_e         req_index;

   // accept only while no completion is in flight
   assign rr_ready = rr_valid && !busy;
   assign status_read = read_0 && (req_index == hififo_pkg::REG_INT_STATUS);

   always_ff @(posedge clock)
   begin
      if (pci_reset)
         busy <= 1'b0;
      else if (rc_ready)
         busy <= 1'b0;
      else if (rr_ready)
         busy <= 1'b1;
   end

   // stage 0, request captured
   always_ff @(posedge clock)
   begin
      if (pci_reset)
         read_0 <= 1'b0;
      else
         read_0 <= rr_ready;
   end

   always_ff @(posedge clock)
   begin
      if (rr_ready)
      begin
         req_index <= rr_index;
         rc_rid_tag <= rr_rid_tag;
         rc_lower_addr <= rr_lower_addr;
      end
   end

   // stage 1, data selected and completion raised
   always_ff @(posedge clock)
   begin
      if (pci_reset)
         rc_valid <= 1'b0;
      else if (rc_ready)
         rc_valid <= 1'b0;
      else if (read_0)
         rc_valid <= 1'b1;
   end

   always_ff @(posedge clock)
   begin
      if (read_0)
      begin
         case (req_index)
            hififo_pkg::REG_INT_STATUS:  rc_data <= 32'(int_status);
            hififo_pkg::REG_ID:          rc_data <= hififo_pkg::BRIDGE_ID;
            hififo_pkg::REG_RESET_SET:   rc_data <= {31'd0, fifo_reset};
            hififo_pkg::REG_RESET_CLEAR: rc_data <= {31'd0, fifo_reset};
            hififo_pkg::REG_FIFO_STATUS: rc_data <= fifo_status;
            default:                     rc_data <= 32'd0;
         endcase
      end
   end

   // read clears, events arriving in the same cycle are kept
   always_ff @(posedge clock)
   begin
      if (pci_reset)
         int_status <= '0;
      else if (status_read)
         int_status <= int_events;
      else
         int_status <= int_status | int_events;
   end

   always_ff @(posedge clock)
   begin
      if (pci_reset)
         interrupt <= 1'b0;
      else
         interrupt <= (|int_events) || (interrupt && !interrupt_rdy);
   end

   // FIFO held in reset until the host clears it
   always_ff @(posedge clock)
   begin
      if (pci_reset)
         fifo_reset <= 1'b1;
      else if (wr_strobe && wr_data[0])
      begin
         if (wr_index == hififo_pkg::REG_RESET_SET)
            fifo_reset <= 1'b1;
         else if (wr_index == hififo_pkg::REG_RESET_CLEAR)
            fifo_reset <= 1'b0;
      end
   end

endmodule

/* verilog/pio_fifo.sv */
// host-to-user FIFO with show-ahead output, fill status and events

`timescale 1ns/1ps

module pio_fifo
  (
   input                                clock,
   input                                reset,
   input                                push,
   input        [31:0]                  push_data,
   input                                fifo_read,
   output logic [31:0]                  fifo_data,
   output logic                         fifo_valid,
   output logic [31:0]                  status,
   output logic [hififo_pkg::NUM_INT-1:0] events
   );

   logic [31:0]                  mem [hififo_pkg::FIFO_DEPTH];
   logic [hififo_pkg::FIFO_AW-1:0] wr_ptr;
   logic [hififo_pkg::FIFO_AW-1:0] rd_ptr;
   logic [hififo_pkg::FIFO_AW:0]   count;
   logic                         full;
   logic                         push_ok;
   logic                         pop;

   assign full = (count == (hififo_pkg::FIFO_AW + 1)'(hififo_pkg::FIFO_DEPTH));
   assign push_ok = push && !full;
   assign pop = fifo_read && fifo_valid;

   // show-ahead, head word always on the output
   assign fifo_data = mem[rd_ptr];
   assign fifo_valid = (count != '0);
   assign status = 32'(count);

   always_ff @(posedge clock)
   begin
      if (push_ok)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push_ok, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // event 0 on the first word, event 1 on a lost word
   always_ff @(posedge clock)
   begin
      if (reset)
         events <= '0;
      else
      begin
         events[0] <= push_ok && (count == '0);
         events[1] <= push && full;
      end
   end

endmodule

/* verilog/pcie_tx.sv */
// completion formatter onto the 64-bit transmit stream

`timescale 1ns/1ps

module pcie_tx
  (
   input                                 clock,
   input                                 pci_reset,
   input        [15:0]                   pci_id,
   input                                 rc_valid,
   input        [31:0]                   rc_data,
   input        [23:0]                   rc_rid_tag,
   input        [6:0]                    rc_lower_addr,
   output logic                          rc_ready,
   input                                 tx_tready,
   output logic                          tx_tvalid,
   output logic                          tx_tlast,
   output logic [hififo_pkg::DATA_W-1:0] tx_tdata
   );

   typedef enum logic [1:0]
   {
      IDLE,
      BEAT0,
      BEAT1
   } tx_state_e;

   tx_state_e   state;
   logic [31:0] cpl_dw0;
   logic [31:0] cpl_dw1;
   logic [31:0] cpl_dw2;

   // length 1 DW
   assign cpl_dw0 = {hififo_pkg::CPLD, 8'h00, 16'h0001};
   // completer ID, successful status, byte count 4
   assign cpl_dw1 = {pci_id, 3'b000, 1'b0, 12'd4};
   assign cpl_dw2 = {rc_rid_tag, 1'b0, rc_lower_addr};

   assign tx_tvalid = (state != IDLE);
   assign tx_tlast = (state == BEAT1);
   assign rc_ready = (state == BEAT1) && tx_tready;

   always_ff @(posedge clock)
   begin
      if (pci_reset)
         state <= IDLE;
      else
      begin
         case (state)
            IDLE:
            begin
               if (rc_valid)
                  state <= BEAT0;
            end
            BEAT0:
            begin
               if (tx_tready)
                  state <= BEAT1;
            end
            BEAT1:
            begin
               if (tx_tready)
                  state <= IDLE;
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   // data only advances on an accepted beat
   always_ff @(posedge clock)
   begin
      if ((state == IDLE) && rc_valid)
         tx_tdata <= {cpl_dw1, cpl_dw0};
      else if ((state == BEAT0) && tx_tready)
         tx_tdata <= {rc_data, cpl_dw2};
   end

endmodule

/* verilog/hififo_bridge.sv */
// top level joining receive decoder, registers, user FIFO and completion formatter

`timescale 1ns/1ps

module hififo_bridge
  (
   input                                 clock,
   input                                 pci_reset,
   input        [15:0]                   pci_id,
   input                                 rx_tvalid,
   input                                 rx_tlast,
   input        [hififo_pkg::DATA_W-1:0] rx_tdata,
   output logic                          tx_tvalid,
   output logic                          tx_tlast,
   output logic [hififo_pkg::DATA_W-1:0] tx_tdata,
   input                                 tx_tready,
   output logic                          interrupt,
   input                                 interrupt_rdy,
   output logic                          fifo_reset,
   input                                 fifo_read,
   output logic [31:0]                   fifo_data,
   output logic                          fifo_valid
   );

   // register writes
   logic                  wr_strobe;
   hififo_pkg::reg_addr_e wr_index;
   logic [31:0]           wr_data;

   // read request
   logic                  rr_valid;
   logic                  rr_ready;
   hififo_pkg::reg_addr_e rr_index;
   logic [23:0]           rr_rid_tag;
   logic [6:0]            rr_lower_addr;

   // read completion
   logic                  rc_valid;
   logic                  rc_ready;
   logic [31:0]           rc_data;
   logic [23:0]           rc_rid_tag;
   logic [6:0]            rc_lower_addr;

   logic [31:0]                    fifo_status;
   logic [hififo_pkg::NUM_INT-1:0] int_events;

   pcie_rx rx_i
     (.clock(clock), .pci_reset(pci_reset),
      .tvalid(rx_tvalid), .tlast(rx_tlast), .tdata(rx_tdata),
      .rr_ready(rr_ready),
      .wr_strobe(wr_strobe), .wr_index(wr_index), .wr_data(wr_data),
      .rr_valid(rr_valid), .rr_index(rr_index),
      .rr_rid_tag(rr_rid_tag), .rr_lower_addr(rr_lower_addr));

   hififo_regs regs_i
     (.clock(clock), .pci_reset(pci_reset),
      .wr_strobe(wr_strobe), .wr_index(wr_index), .wr_data(wr_data),
      .rr_valid(rr_valid), .rr_index(rr_index),
      .rr_rid_tag(rr_rid_tag), .rr_lower_addr(rr_lower_addr), .rr_ready(rr_ready),
      .int_events(int_events), .fifo_status(fifo_status), .fifo_reset(fifo_reset),
      .interrupt(interrupt), .interrupt_rdy(interrupt_rdy),
      .rc_valid(rc_valid), .rc_data(rc_data), .rc_rid_tag(rc_rid_tag),
      .rc_lower_addr(rc_lower_addr), .rc_ready(rc_ready));

   // pushed by writes to the data register
   pio_fifo fifo_i
     (.clock(clock), .reset(fifo_reset),
      .push(wr_strobe && (wr_index == hififo_pkg::REG_FIFO_DATA)), .push_data(wr_data),
      .fifo_read(fifo_read), .fifo_data(fifo_data), .fifo_valid(fifo_valid),
      .status(fifo_status), .events(int_events));

   pcie_tx tx_i
     (.clock(clock), .pci_reset(pci_reset), .pci_id(pci_id),
      .rc_valid(rc_valid), .rc_data(rc_data), .rc_rid_tag(rc_rid_tag),
      .rc_lower_addr(rc_lower_addr), .rc_ready(rc_ready),
      .tx_tready(tx_tready), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast),
      .tx_tdata(tx_tdata));

endmodule

/* test/hififo_props.sv */
// concurrent checks on the transmit stream and the interrupt request, bound to the bridge

`timescale 1ns/1ps

module hififo_props
  (
   input                                 clock,
   input                                 pci_reset,
   input                                 tx_tvalid,
   input                                 tx_tlast,
   input        [hififo_pkg::DATA_W-1:0] tx_tdata,
   input                                 tx_tready,
   input                                 interrupt,
   input                                 interrupt_rdy
   );

   int fail_count = 0;

   // a stalled beat keeps its valid and its data
   tx_hold: assert property (@(posedge clock) disable iff (pci_reset)
      tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata))
   else
   begin
      fail_count = fail_count + 1;
      $error("transmit beat changed while tready was low");
   end

   // tlast only on a valid beat, never the opening one
   tx_last_valid: assert property (@(posedge clock) disable iff (pci_reset)
      tx_tlast |-> tx_tvalid && $past(tx_tvalid))
   else
   begin
      fail_count = fail_count + 1;
      $error("tlast seen without tvalid or on the opening beat");
   end

   // request held until the core takes it
   int_hold: assert property (@(posedge clock) disable iff (pci_reset)
      interrupt && !interrupt_rdy |=> interrupt)
   else
   begin
      fail_count = fail_count + 1;
      $error("interrupt dropped before interrupt_rdy");
   end

endmodule

bind hififo_bridge hififo_props props_i
  (.clock(clock), .pci_reset(pci_reset),
   .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tdata(tx_tdata),
   .tx_tready(tx_tready), .interrupt(interrupt), .interrupt_rdy(interrupt_rdy));

/* test/hififo_tb.sv */
// testbench for the bridge with host TLP tasks, user FIFO reads and register checks

`timescale 1ns/1ps

module hififo_tb;

   localparam int          TIMEOUT = 200;
   localparam logic [15:0] PCI_ID = 16'h0300;
   localparam logic [31:0] BAR_BASE = 32'hF7C0_0000;

   logic        clock;
   logic        pci_reset;
   logic [15:0] pci_id;
   logic        rx_tvalid;
   logic        rx_tlast;
   logic [63:0] rx_tdata;
   logic        tx_tvalid;
   logic        tx_tlast;
   logic [63:0] tx_tdata;
   logic        tx_tready;
   logic        interrupt;
   logic        interrupt_rdy;
   logic        fifo_reset;
   logic        fifo_read;
   logic [31:0] fifo_data;
   logic        fifo_valid;

   // accepted transmit beats, tlast in bit 64
   logic [64:0] tx_beats[$];
   // words expected at the user side
   logic [31:0] fifo_model[$];

   hififo_bridge dut_i
     (.clock(clock), .pci_reset(pci_reset), .pci_id(pci_id),
      .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tdata(rx_tdata),
      .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tdata(tx_tdata),
      .tx_tready(tx_tready), .interrupt(interrupt), .interrupt_rdy(interrupt_rdy),
      .fifo_reset(fifo_reset), .fifo_read(fifo_read),
      .fifo_data(fifo_data), .fifo_valid(fifo_valid));

   initial
   begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   always @(posedge clock)
   begin
      if (tx_tvalid && tx_tready)
         tx_beats.push_back({tx_tlast, tx_tdata});
   end

   always @(dut_i.props_i.fail_count)
   begin
      if (dut_i.props_i.fail_count != 0)
      begin
         $display("Protocol assertion failed on the transmit stream or interrupt");
         $display("Some tests failed");
         $fatal(1);
      end
   end

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else
      begin
         $display("Error %s: expected %0h, actual %0h", name, expected, actual);
         $display("Some tests failed");
         $fatal(1);
      end
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timeout: %s", what);
      $display("Some tests failed");
      $fatal(1);
   endtask

   // tready low about one cycle in four
   task automatic drive_random_ready();
      forever
      begin
         @(negedge clock);
         tx_tready = ($urandom_range(3) != 0);
      end
   endtask

   // two beats of a 3-DW request with one data DW
   task automatic send_tlp(input logic [31:0] dw0, input logic [31:0] dw1,
                           input logic [31:0] dw2, input logic [31:0] data);
      @(negedge clock);
      rx_tvalid = 1'b1;
      rx_tlast = 1'b0;
      rx_tdata = {dw1, dw0};
      @(negedge clock);
      rx_tlast = 1'b1;
      rx_tdata = {data, dw2};
      @(negedge clock);
      rx_tvalid = 1'b0;
      rx_tlast = 1'b0;
      rx_tdata = '0;
   endtask

   task automatic write_register(input logic [3:0] index, input logic [31:0] data);
      send_tlp({hififo_pkg::MWR32, 8'h00, 16'h0001}, {16'h0100, 8'h00, 8'h0F},
               BAR_BASE | {25'd0, index, 3'b000}, data);
   endtask

   task automatic read_register(input string name, input logic [3:0] index,
                                output logic [31:0] data);
      logic [23:0] rid_tag;
      logic [6:0]  lower_addr;
      logic [64:0] beat;
      int          n;
      rid_tag = 24'($urandom);
      lower_addr = {index, 3'b000};
      tx_beats.delete();
      send_tlp({hififo_pkg::MRD32, 8'h00, 16'h0001}, {rid_tag, 8'h0F},
               BAR_BASE | {25'd0, index, 3'b000}, 32'd0);
      n = 0;
      while ((tx_beats.size() < 2) && (n < TIMEOUT))
      begin
         @(negedge clock);
         n++;
      end
      if (tx_beats.size() < 2)
         stop_on_timeout("no completion for a register read");
      // completer header, length 1 and byte count 4
      beat = tx_beats.pop_front();
      check_value({name, " beat 0 tlast"}, 1'b0, beat[64]);
      check_value({name, " beat 0"},
                  {PCI_ID, 16'h0004, hififo_pkg::CPLD, 8'h00, 16'h0001}, beat[63:0]);
      beat = tx_beats.pop_front();
      check_value({name, " beat 1 tlast"}, 1'b1, beat[64]);
      check_value({name, " requester"}, {rid_tag, 1'b0, lower_addr}, beat[31:0]);
      data = beat[63:32];
   endtask

   task automatic read_and_check(input string name, input logic [3:0] index,
                                 input logic [31:0] expected);
      logic [31:0] data;
      read_register(name, index, data);
      check_value(name, expected, data);
   endtask

   task automatic wait_fifo_reset(input logic value);
      int n;
      n = 0;
      while ((fifo_reset !== value) && (n < TIMEOUT))
      begin
         @(negedge clock);
         n++;
      end
      if (fifo_reset !== value)
         stop_on_timeout("fifo_reset did not follow the register write");
   endtask

   task automatic wait_interrupt(input logic value);
      int n;
      n = 0;
      while ((interrupt !== value) && (n < TIMEOUT))
      begin
         @(negedge clock);
         n++;
      end
      if (interrupt !== value)
         stop_on_timeout("interrupt did not reach the expected level");
   endtask

   // user side read of one word, compared against the model
   task automatic pop_word(input string name);
      int n;
      n = 0;
      while (!fifo_valid && (n < TIMEOUT))
      begin
         @(negedge clock);
         n++;
      end
      if (!fifo_valid)
         stop_on_timeout("user FIFO stayed empty");
      check_value(name, fifo_model.pop_front(), fifo_data);
      fifo_read = 1'b1;
      @(negedge clock);
      fifo_read = 1'b0;
   endtask

   task automatic push_words(input int count);
      logic [31:0] word;
      for (int i = 0; i < count; i++)
      begin
         word = $urandom;
         write_register(hififo_pkg::REG_FIFO_DATA, word);
         if (fifo_model.size() < hififo_pkg::FIFO_DEPTH)
            fifo_model.push_back(word);
      end
   endtask

   initial
   begin
      void'($urandom(32'h1c8e));
      pci_reset = 1'b1;
      pci_id = PCI_ID;
      rx_tvalid = 1'b0;
      rx_tlast = 1'b0;
      rx_tdata = '0;
      tx_tready = 1'b1;
      interrupt_rdy = 1'b0;
      fifo_read = 1'b0;
      repeat (5) @(posedge clock);
      @(negedge clock);
      pci_reset = 1'b0;
      fork
         drive_random_ready();
      join_none

      // FIFO reset bit
      check_value("reset_initial", 1'b1, fifo_reset);
      read_and_check("reset_set_initial", hififo_pkg::REG_RESET_SET, 32'd1);
      write_register(hififo_pkg::REG_RESET_CLEAR, 32'd1);
      wait_fifo_reset(1'b0);
      read_and_check("reset_set_cleared", hififo_pkg::REG_RESET_SET, 32'd0);
      read_and_check("reset_clear_cleared", hififo_pkg::REG_RESET_CLEAR, 32'd0);
      write_register(hififo_pkg::REG_RESET_SET, 32'd1);
      wait_fifo_reset(1'b1);
      read_and_check("reset_set_restored", hififo_pkg::REG_RESET_SET, 32'd1);
      write_register(hififo_pkg::REG_RESET_CLEAR, 32'd1);
      wait_fifo_reset(1'b0);

      // ID and unused addresses, under tready stalls
      for (int i = 0; i < 4; i++)
         read_and_check("id_read", hififo_pkg::REG_ID, hififo_pkg::BRIDGE_ID);
      read_and_check("unused_read_5", 4'd5, 32'd0);
      read_and_check("unused_read_15", 4'd15, 32'd0);

      // first word into an empty FIFO
      check_value("interrupt_idle", 1'b0, interrupt);
      push_words(1);
      wait_interrupt(1'b1);
      repeat (4) @(negedge clock);
      check_value("interrupt_hold", 1'b1, interrupt);
      interrupt_rdy = 1'b1;
      @(negedge clock);
      interrupt_rdy = 1'b0;
      wait_interrupt(1'b0);
      read_and_check("int_status_first", hififo_pkg::REG_INT_STATUS, 32'd1);
      read_and_check("int_status_cleared", hififo_pkg::REG_INT_STATUS, 32'd0);

      // write order and fill level
      push_words(4);
      read_and_check("fifo_status_five", hififo_pkg::REG_FIFO_STATUS, 32'd5);
      pop_word("fifo_order");
      pop_word("fifo_order");
      read_and_check("fifo_status_three", hififo_pkg::REG_FIFO_STATUS, 32'd3);
      while (fifo_model.size() != 0)
         pop_word("fifo_order");
      check_value("fifo_drained", 1'b0, fifo_valid);
      read_and_check("fifo_status_empty", hififo_pkg::REG_FIFO_STATUS, 32'd0);

      // one word past full is lost
      push_words(hififo_pkg::FIFO_DEPTH + 1);
      read_and_check("fifo_status_full", hififo_pkg::REG_FIFO_STATUS,
                     32'(hififo_pkg::FIFO_DEPTH));
      read_and_check("int_status_overflow", hififo_pkg::REG_INT_STATUS, 32'd3);
      while (fifo_model.size() != 0)
         pop_word("fifo_overflow_order");
      check_value("fifo_overflow_drained", 1'b0, fifo_valid);
      interrupt_rdy = 1'b1;
      @(negedge clock);
      interrupt_rdy = 1'b0;
      wait_interrupt(1'b0);

      repeat (4) @(negedge clock);
      $display("All tests passed");
      $finish;
   end

endmodule

/* hififo.f */
verilog/hififo_pkg.sv
verilog/pcie_rx.sv
verilog/hififo_regs.sv
verilog/pio_fifo.sv
verilog/pcie_tx.sv
verilog/hififo_bridge.sv
test/hififo_props.sv
test/hififo_tb.sv
